// ==== include/axi_rw_macros.svh ====
`ifndef AXI_RW_MACROS_SVH
`define AXI_RW_MACROS_SVH

// ##################################################
// bus geometry
// ##################################################
`define AXI_ADDR_WIDTH      64
`define AXI_DATA_WIDTH      64
`define AXI_STRB_WIDTH      8   // one bit per data byte
`define AXI_BYTE_OFS_WIDTH  3   // byte offset inside a beat

// ##################################################
// burst limits
// ##################################################
`define AXI_LINE_BEATS      8
`define AXI_LINE_WIDTH      512
`define AXI_BEAT_IDX_WIDTH  3
`define AXI_LEN_WIDTH       8
`define AXI_SIZE_WIDTH      3

`endif

// ==== rtl/axi_rw_pkg.sv ====
package axi_rw_pkg;

  // bridge sequencing
  typedef enum logic [2:0] {
    idle,
    addr_rd,
    data_rd,
    addr_wr,
    data_wr,
    resp_wr,
    done
  } rw_state_e;

  typedef enum logic {
    op_read,
    op_write
  } user_op_e;

  // codes are ordered by severity, so a larger value is worse
  typedef enum logic [1:0] {
    okay   = 2'b00,
    exokay = 2'b01,
    slverr = 2'b10,
    decerr = 2'b11
  } axi_resp_e;

endpackage

// ==== rtl/axi_beat_if.sv ====
`timescale 1ns/1ps
`include "axi_rw_macros.svh"

interface axi_beat_if;

  logic                           load;       // request accepted
  logic                           beat_en;    // one W or R beat transferred
  logic [`AXI_BEAT_IDX_WIDTH-1:0] beat_idx;
  logic                           last_beat;

  modport fsm (
    output load,
    output beat_en,
    input  last_beat
  );

  modport counter (
    input  load,
    input  beat_en,
    output beat_idx,
    output last_beat
  );

  modport data (
    input  load,
    input  beat_en,
    input  beat_idx,
    input  last_beat
  );

endinterface

// ==== rtl/axi_rw_fsm.sv ====
`timescale 1ns/1ps

module axi_rw_fsm (
  input  logic                 clock,
  input  logic                 rst_i,
  input  logic                 user_valid_i,
  input  axi_rw_pkg::user_op_e user_op_i,
  input  logic                 ar_ready_i,
  input  logic                 r_valid_i,
  input  logic                 r_last_i,
  input  logic                 aw_ready_i,
  input  logic                 w_ready_i,
  input  logic                 b_valid_i,
  output logic                 ar_valid_o,
  output logic                 r_ready_o,
  output logic                 aw_valid_o,
  output logic                 w_valid_o,
  output logic                 b_ready_o,
  output logic                 user_ready_o,
  axi_beat_if.fsm              beat
);

  axi_rw_pkg::rw_state_e state_q;
  axi_rw_pkg::rw_state_e state_d;
  logic                  r_fire;
  logic                  w_fire;

  // ##################################################
  // channel controls decoded from state
  // ##################################################
  assign ar_valid_o   = (state_q == axi_rw_pkg::addr_rd);
  assign r_ready_o    = (state_q == axi_rw_pkg::data_rd);
  assign aw_valid_o   = (state_q == axi_rw_pkg::addr_wr);
  assign w_valid_o    = (state_q == axi_rw_pkg::data_wr);
  assign b_ready_o    = (state_q == axi_rw_pkg::resp_wr);
  assign user_ready_o = (state_q == axi_rw_pkg::done);     // single cycle

  assign r_fire = r_valid_i & r_ready_o;
  assign w_fire = w_valid_o & w_ready_i;

  assign beat.load    = (state_q == axi_rw_pkg::idle) & user_valid_i;
  assign beat.beat_en = r_fire | w_fire;

  // ##################################################
  // next state
  // ##################################################
  always_comb begin
    state_d = state_q;
    unique case (state_q)
      axi_rw_pkg::idle: begin
        if (user_valid_i) begin
          state_d = (user_op_i == axi_rw_pkg::op_write) ? axi_rw_pkg::addr_wr
                                                        : axi_rw_pkg::addr_rd;
        end
      end
      axi_rw_pkg::addr_rd: begin
        if (ar_ready_i) begin
          state_d = axi_rw_pkg::data_rd;
        end
      end
      axi_rw_pkg::data_rd: begin
        if (r_fire && r_last_i) begin   // slave marks the end of the burst
          state_d = axi_rw_pkg::done;
        end
      end
      axi_rw_pkg::addr_wr: begin
        if (aw_ready_i) begin
          state_d = axi_rw_pkg::data_wr;
        end
      end
      axi_rw_pkg::data_wr: begin
        if (w_fire && beat.last_beat) begin
          state_d = axi_rw_pkg::resp_wr;
        end
      end
      axi_rw_pkg::resp_wr: begin
        if (b_valid_i) begin
          state_d = axi_rw_pkg::done;
        end
      end
      axi_rw_pkg::done: begin
        state_d = axi_rw_pkg::idle;
      end
      default: begin
        state_d = axi_rw_pkg::idle;
      end
    endcase
  end

  always_ff @(posedge clock) begin
    if (rst_i) begin
      state_q <= axi_rw_pkg::idle;
    end else begin
      state_q <= state_d;
    end
  end

  // address valids may not drop before the slave takes them
  ar_hold_a : assert property (@(posedge clock) disable iff (rst_i)
    ar_valid_o && !ar_ready_i |=> ar_valid_o);

  aw_hold_a : assert property (@(posedge clock) disable iff (rst_i)
    aw_valid_o && !aw_ready_i |=> aw_valid_o);

  // write data only opens right after an accepted write address
  w_after_aw_a : assert property (@(posedge clock) disable iff (rst_i)
    $rose(w_valid_o) |-> $past(aw_valid_o && aw_ready_i));

endmodule

// ==== rtl/axi_beat_counter.sv ====
`timescale 1ns/1ps
`include "axi_rw_macros.svh"

module axi_beat_counter (
  input  logic                           clock,
  input  logic                           rst_i,
  input  logic [`AXI_BEAT_IDX_WIDTH-1:0] user_blks_i,  // beats minus one
  axi_beat_if.counter                    beat,
  output logic [`AXI_LEN_WIDTH-1:0]      axi_len_o
);

  logic [`AXI_BEAT_IDX_WIDTH-1:0] idx_q;
  logic [`AXI_BEAT_IDX_WIDTH-1:0] cnt_q;   // latched burst length

  always_ff @(posedge clock) begin
    if (rst_i) begin
      idx_q <= '0;
      cnt_q <= '0;
    end else if (beat.load) begin
      idx_q <= '0;
      cnt_q <= user_blks_i;
    end else if (beat.beat_en && (idx_q != cnt_q)) begin
      idx_q <= idx_q + `AXI_BEAT_IDX_WIDTH'(1);   // parks on the final beat
    end
  end

  assign beat.beat_idx  = idx_q;
  assign beat.last_beat = (idx_q == cnt_q);

  // shared by AR and AW
  assign axi_len_o = {{(`AXI_LEN_WIDTH - `AXI_BEAT_IDX_WIDTH){1'b0}}, cnt_q};

  idx_in_range_a : assert property (@(posedge clock) disable iff (rst_i)
    idx_q <= cnt_q);

endmodule

// ==== rtl/axi_wdata_shifter.sv ====
`timescale 1ns/1ps
`include "axi_rw_macros.svh"

module axi_wdata_shifter (
  input  logic                          clock,
  input  logic                          rst_i,
  input  logic [`AXI_LINE_WIDTH-1:0]    user_wdata_i,
  input  logic [`AXI_ADDR_WIDTH-1:0]    user_addr_i,
  input  logic [1:0]                    user_size_i,
  axi_beat_if.data                      beat,
  output logic [`AXI_DATA_WIDTH-1:0]    w_data_o,
  output logic [`AXI_STRB_WIDTH-1:0]    w_strb_o,
  output logic [`AXI_ADDR_WIDTH-1:0]    axi_addr_o,
  output logic [`AXI_SIZE_WIDTH-1:0]    axi_size_o
);

  logic [`AXI_LINE_BEATS-1:0][`AXI_DATA_WIDTH-1:0] line_q;
  logic [`AXI_ADDR_WIDTH-1:0]                      addr_q;
  logic [1:0]                                      size_q;
  logic [`AXI_STRB_WIDTH-1:0]                      mask;

  always_ff @(posedge clock) begin
    if (beat.load) begin
      line_q <= user_wdata_i;
    end
  end

  always_ff @(posedge clock) begin
    if (rst_i) begin
      addr_q <= '0;
      size_q <= '0;
    end else if (beat.load) begin
      addr_q <= user_addr_i;
      size_q <= user_size_i;
    end
  end

  // 2^size bytes, unshifted
  always_comb begin
    unique case (size_q)
      2'd0:    mask = `AXI_STRB_WIDTH'('h01);
      2'd1:    mask = `AXI_STRB_WIDTH'('h03);
      2'd2:    mask = `AXI_STRB_WIDTH'('h0f);
      default: mask = '1;
    endcase
  end

  assign w_data_o = line_q[beat.beat_idx];
  assign w_strb_o = (size_q == 2'd3) ? mask
                                     : mask << addr_q[`AXI_BYTE_OFS_WIDTH-1:0];

  assign axi_addr_o = addr_q;
  assign axi_size_o = {1'b0, size_q};

endmodule

// ==== rtl/axi_rdata_collector.sv ====
`timescale 1ns/1ps
`include "axi_rw_macros.svh"

module axi_rdata_collector (
  input  logic                          clock,
  input  logic                          rst_i,
  input  logic [`AXI_DATA_WIDTH-1:0]    r_data_i,
  input  logic [1:0]                    r_resp_i,
  input  logic [1:0]                    b_resp_i,
  input  axi_rw_pkg::user_op_e          user_op_i,
  axi_beat_if.data                      beat,
  output logic [`AXI_LINE_WIDTH-1:0]    user_rdata_o,
  output axi_rw_pkg::axi_resp_e         user_resp_o
);

  logic [`AXI_LINE_BEATS-1:0][`AXI_DATA_WIDTH-1:0] line_q;
  axi_rw_pkg::axi_resp_e                           resp_q;
  logic                                            rd_beat;
  logic                                            burst_end_q;  // final beat seen

  assign rd_beat = beat.beat_en & (user_op_i == axi_rw_pkg::op_read);

  always_ff @(posedge clock) begin
    if (rd_beat) begin
      line_q[beat.beat_idx] <= r_data_i;   // beat k lands in slot k
    end
  end

  // ##################################################
  // response tracking
  // ##################################################
  always_ff @(posedge clock) begin
    if (rst_i) begin
      resp_q <= axi_rw_pkg::okay;
    end else if (beat.load) begin
      resp_q <= axi_rw_pkg::okay;
    end else if (user_op_i == axi_rw_pkg::op_write) begin
      // the FSM leaves resp_wr on the B handshake edge, so the value
      // sampled there is what the done cycle presents
      if (beat.last_beat) begin
        resp_q <= axi_rw_pkg::axi_resp_e'(b_resp_i);
      end
    end else if (rd_beat && (r_resp_i > resp_q)) begin
      resp_q <= axi_rw_pkg::axi_resp_e'(r_resp_i);   // keep the worst
    end
  end

  always_ff @(posedge clock) begin
    if (rst_i) begin
      burst_end_q <= 1'b0;
    end else if (beat.load) begin
      burst_end_q <= 1'b0;
    end else if (beat.beat_en && beat.last_beat) begin
      burst_end_q <= 1'b1;
    end
  end

  assign user_rdata_o = line_q;
  assign user_resp_o  = resp_q;

  // no read beat past the end of the burst until the next request
  no_beat_after_last_a : assert property (@(posedge clock) disable iff (rst_i)
    rd_beat |-> !burst_end_q);

endmodule

// ==== rtl/axi_rw_top.sv ====
`timescale 1ns/1ps
`include "axi_rw_macros.svh"

module axi_rw_top (
  input  logic                           clock,
  input  logic                           rst_i,

  // user request port
  input  logic                           user_valid_i,
  input  axi_rw_pkg::user_op_e           user_op_i,
  input  logic [`AXI_ADDR_WIDTH-1:0]     user_addr_i,
  input  logic [1:0]                     user_size_i,
  input  logic [`AXI_BEAT_IDX_WIDTH-1:0] user_blks_i,
  input  logic [`AXI_LINE_WIDTH-1:0]     user_wdata_i,
  output logic                           user_ready_o,
  output logic [`AXI_LINE_WIDTH-1:0]     user_rdata_o,
  output axi_rw_pkg::axi_resp_e          user_resp_o,

  // write address
  output logic                           aw_valid_o,
  input  logic                           aw_ready_i,
  output logic [`AXI_ADDR_WIDTH-1:0]     aw_addr_o,
  output logic [`AXI_LEN_WIDTH-1:0]      aw_len_o,
  output logic [`AXI_SIZE_WIDTH-1:0]     aw_size_o,

  // write data
  output logic                           w_valid_o,
  input  logic                           w_ready_i,
  output logic [`AXI_DATA_WIDTH-1:0]     w_data_o,
  output logic [`AXI_STRB_WIDTH-1:0]     w_strb_o,
  output logic                           w_last_o,

  // write response
  input  logic                           b_valid_i,
  output logic                           b_ready_o,
  input  logic [1:0]                     b_resp_i,

  // read address
  output logic                           ar_valid_o,
  input  logic                           ar_ready_i,
  output logic [`AXI_ADDR_WIDTH-1:0]     ar_addr_o,
  output logic [`AXI_LEN_WIDTH-1:0]      ar_len_o,
  output logic [`AXI_SIZE_WIDTH-1:0]     ar_size_o,

  // read data
  input  logic                           r_valid_i,
  output logic                           r_ready_o,
  input  logic [`AXI_DATA_WIDTH-1:0]     r_data_i,
  input  logic [1:0]                     r_resp_i,
  input  logic                           r_last_i
);

  logic [`AXI_ADDR_WIDTH-1:0] axi_addr;
  logic [`AXI_LEN_WIDTH-1:0]  axi_len;
  logic [`AXI_SIZE_WIDTH-1:0] axi_size;

  axi_beat_if beat_if ();

  // ##################################################
  // control
  // ##################################################
  axi_rw_fsm u_fsm (
    .clock        (clock),
    .rst_i        (rst_i),
    .user_valid_i (user_valid_i),
    .user_op_i    (user_op_i),
    .ar_ready_i   (ar_ready_i),
    .r_valid_i    (r_valid_i),
    .r_last_i     (r_last_i),
    .aw_ready_i   (aw_ready_i),
    .w_ready_i    (w_ready_i),
    .b_valid_i    (b_valid_i),
    .ar_valid_o   (ar_valid_o),
    .r_ready_o    (r_ready_o),
    .aw_valid_o   (aw_valid_o),
    .w_valid_o    (w_valid_o),
    .b_ready_o    (b_ready_o),
    .user_ready_o (user_ready_o),
    .beat         (beat_if.fsm)
  );

  axi_beat_counter u_counter (
    .clock       (clock),
    .rst_i       (rst_i),
    .user_blks_i (user_blks_i),
    .beat        (beat_if.counter),
    .axi_len_o   (axi_len)
  );

  // ##################################################
  // data path
  // ##################################################
  axi_wdata_shifter u_wdata (
    .clock        (clock),
    .rst_i        (rst_i),
    .user_wdata_i (user_wdata_i),
    .user_addr_i  (user_addr_i),
    .user_size_i  (user_size_i),
    .beat         (beat_if.data),
    .w_data_o     (w_data_o),
    .w_strb_o     (w_strb_o),
    .axi_addr_o   (axi_addr),
    .axi_size_o   (axi_size)
  );

  axi_rdata_collector u_rdata (
    .clock        (clock),
    .rst_i        (rst_i),
    .r_data_i     (r_data_i),
    .r_resp_i     (r_resp_i),
    .b_resp_i     (b_resp_i),
    .user_op_i    (user_op_i),
    .beat         (beat_if.data),
    .user_rdata_o (user_rdata_o),
    .user_resp_o  (user_resp_o)
  );

  // both address channels carry the same request
  assign aw_addr_o = axi_addr;
  assign aw_len_o  = axi_len;
  assign aw_size_o = axi_size;
  assign ar_addr_o = axi_addr;
  assign ar_len_o  = axi_len;
  assign ar_size_o = axi_size;

  assign w_last_o = beat_if.last_beat;

endmodule

// ==== tests/axi_slave_model.sv ====
`timescale 1ns/1ps
`include "axi_rw_macros.svh"

module axi_slave_model #(
  parameter logic [7:0] ERR_FIRST = 8'hf0   // first word of the error window
) (
  input  logic                        clock,
  input  logic [4:0]                  stall_i,   // aw, w, b, ar, r
  input  logic                        aw_valid_i,
  output logic                        aw_ready_o,
  input  logic [`AXI_ADDR_WIDTH-1:0]  aw_addr_i,
  input  logic                        w_valid_i,
  output logic                        w_ready_o,
  input  logic [`AXI_DATA_WIDTH-1:0]  w_data_i,
  input  logic [`AXI_STRB_WIDTH-1:0]  w_strb_i,
  input  logic                        w_last_i,
  output logic                        b_valid_o,
  input  logic                        b_ready_i,
  output logic [1:0]                  b_resp_o,
  input  logic                        ar_valid_i,
  output logic                        ar_ready_o,
  input  logic [`AXI_ADDR_WIDTH-1:0]  ar_addr_i,
  input  logic [`AXI_LEN_WIDTH-1:0]   ar_len_i,
  output logic                        r_valid_o,
  input  logic                        r_ready_i,
  output logic [`AXI_DATA_WIDTH-1:0]  r_data_o,
  output logic [1:0]                  r_resp_o,
  output logic                        r_last_o
);

  logic [`AXI_DATA_WIDTH-1:0] mem [256];
  logic [7:0]                 wr_idx;
  logic [7:0]                 rd_idx;
  logic [8:0]                 rd_left;
  logic                       wr_open;
  logic                       wr_err;
  logic                       b_pend;
  logic                       rd_open;

  // bus as seen at the previous falling edge, i.e. at the rising edge in between
  logic                       aw_v_q;
  logic                       w_v_q;
  logic                       w_last_q;
  logic                       b_rdy_q;
  logic                       ar_v_q;
  logic                       r_rdy_q;
  logic [`AXI_ADDR_WIDTH-1:0] aw_addr_q;
  logic [`AXI_ADDR_WIDTH-1:0] ar_addr_q;
  logic [`AXI_DATA_WIDTH-1:0] w_data_q;
  logic [`AXI_STRB_WIDTH-1:0] w_strb_q;
  logic [`AXI_LEN_WIDTH-1:0]  ar_len_q;

  function automatic logic in_window(input logic [7:0] idx);
    return idx >= ERR_FIRST;
  endfunction

  initial begin
    for (int i = 0; i < 256; i++) begin
      mem[i] = 64'h9e37_79b9_7f4a_7c15 * 64'(i + 1);   // every word distinct
    end
    {aw_ready_o, w_ready_o, b_valid_o, ar_ready_o, r_valid_o, r_last_o} = '0;
    b_resp_o = 2'b00;
    r_resp_o = 2'b00;
    r_data_o = '0;
    {wr_idx, rd_idx, rd_left, wr_open, wr_err, b_pend, rd_open} = '0;
    {aw_v_q, w_v_q, w_last_q, b_rdy_q, ar_v_q, r_rdy_q} = '0;
    {aw_addr_q, ar_addr_q, w_data_q, w_strb_q, ar_len_q} = '0;

    forever begin
      @(negedge clock);
      // ##################################################
      // transfers completed on the last rising edge
      // ##################################################
      if (aw_v_q && aw_ready_o) begin
        wr_idx  = aw_addr_q[10:3];
        wr_err  = 1'b0;
        wr_open = 1'b1;
      end
      if (w_v_q && w_ready_o) begin
        if (in_window(wr_idx)) begin
          wr_err = 1'b1;                        // data dropped
        end else begin
          for (int j = 0; j < `AXI_STRB_WIDTH; j++) begin
            if (w_strb_q[j]) mem[wr_idx][8*j +: 8] = w_data_q[8*j +: 8];
          end
        end
        wr_idx = wr_idx + 8'd1;
        if (w_last_q) begin
          wr_open = 1'b0;
          b_pend  = 1'b1;
        end
      end
      if (b_valid_o && b_rdy_q) begin
        b_pend    = 1'b0;
        b_valid_o = 1'b0;
      end
      if (ar_v_q && ar_ready_o) begin
        rd_idx  = ar_addr_q[10:3];
        rd_left = {1'b0, ar_len_q} + 9'd1;
        rd_open = 1'b1;
      end
      if (r_valid_o && r_rdy_q) begin
        rd_idx    = rd_idx + 8'd1;
        rd_left   = rd_left - 9'd1;
        r_valid_o = 1'b0;
        if (rd_left == 9'd0) rd_open = 1'b0;
      end

      // ##################################################
      // outputs for the next cycle
      // ##################################################
      aw_ready_o = !wr_open && !b_pend && !stall_i[0];
      w_ready_o  = wr_open && !stall_i[1];
      ar_ready_o = !rd_open && !stall_i[3];
      if (b_pend && !b_valid_o && !stall_i[2]) begin
        b_valid_o = 1'b1;
        b_resp_o  = wr_err ? 2'b10 : 2'b00;
      end
      if (rd_open && !r_valid_o && !stall_i[4]) begin   // held until taken
        r_valid_o = 1'b1;
        r_data_o  = mem[rd_idx];
        r_resp_o  = in_window(rd_idx) ? 2'b10 : 2'b00;
        r_last_o  = (rd_left == 9'd1);
      end

      aw_v_q    = aw_valid_i;
      aw_addr_q = aw_addr_i;
      w_v_q     = w_valid_i;
      w_data_q  = w_data_i;
      w_strb_q  = w_strb_i;
      w_last_q  = w_last_i;
      b_rdy_q   = b_ready_i;
      ar_v_q    = ar_valid_i;
      ar_addr_q = ar_addr_i;
      ar_len_q  = ar_len_i;
      r_rdy_q   = r_ready_i;
    end
  end

endmodule

// ==== tests/tb_axi_rw.sv ====
`timescale 1ns/1ps
`include "axi_rw_macros.svh"

module tb_axi_rw;

  localparam int         TIMEOUT_CYCLES = 500;
  localparam logic [7:0] ERR_FIRST      = 8'hf0;
  localparam int         NUM_BASE       = 7;

  typedef struct packed {
    axi_rw_pkg::user_op_e           op;
    logic [`AXI_ADDR_WIDTH-1:0]     addr;
    logic [1:0]                     size;
    logic [`AXI_BEAT_IDX_WIDTH-1:0] blks;
    logic [`AXI_LINE_WIDTH-1:0]     wline;
    logic [`AXI_LINE_WIDTH-1:0]     exp_line;
    axi_rw_pkg::axi_resp_e          exp_resp;
    logic                           stall;
  } req_t;

  // request shapes, run once without and once with stalls
  axi_rw_pkg::user_op_e base_op [NUM_BASE] = '{
    axi_rw_pkg::op_write, axi_rw_pkg::op_read, axi_rw_pkg::op_write, axi_rw_pkg::op_read,
    axi_rw_pkg::op_write, axi_rw_pkg::op_read, axi_rw_pkg::op_read};
  logic [63:0] base_addr [NUM_BASE] = '{
    64'h100, 64'h100, 64'h203, 64'h200, 64'h7c0, 64'h760, 64'h340};
  logic [1:0]  base_size [NUM_BASE] = '{2'd3, 2'd3, 2'd1, 2'd3, 2'd3, 2'd3, 2'd3};
  logic [2:0]  base_blks [NUM_BASE] = '{3'd7, 3'd7, 3'd0, 3'd0, 3'd3, 3'd7, 3'd4};

  req_t        reqs [$];
  logic [63:0] shadow [256];
  logic [31:0] lfsr_state = 32'he6546da1;
  logic [4:0]  stall;
  logic        stall_on;

  logic                           clock;
  logic                           rst_i;
  logic                           user_valid_i;
  axi_rw_pkg::user_op_e           user_op_i;
  logic [`AXI_ADDR_WIDTH-1:0]     user_addr_i;
  logic [1:0]                     user_size_i;
  logic [`AXI_BEAT_IDX_WIDTH-1:0] user_blks_i;
  logic [`AXI_LINE_WIDTH-1:0]     user_wdata_i;
  logic                           user_ready_o;
  logic [`AXI_LINE_WIDTH-1:0]     user_rdata_o;
  axi_rw_pkg::axi_resp_e          user_resp_o;
  logic                           aw_valid;
  logic                           aw_ready;
  logic                           w_valid;
  logic                           w_ready;
  logic                           w_last;
  logic                           b_valid;
  logic                           b_ready;
  logic                           ar_valid;
  logic                           ar_ready;
  logic                           r_valid;
  logic                           r_ready;
  logic                           r_last;
  logic [`AXI_ADDR_WIDTH-1:0]     aw_addr;
  logic [`AXI_LEN_WIDTH-1:0]      aw_len;
  logic [`AXI_SIZE_WIDTH-1:0]     aw_size;
  logic [`AXI_ADDR_WIDTH-1:0]     ar_addr;
  logic [`AXI_LEN_WIDTH-1:0]      ar_len;
  logic [`AXI_SIZE_WIDTH-1:0]     ar_size;
  logic [`AXI_DATA_WIDTH-1:0]     w_data;
  logic [`AXI_DATA_WIDTH-1:0]     r_data;
  logic [`AXI_STRB_WIDTH-1:0]     w_strb;
  logic [1:0]                     b_resp;
  logic [1:0]                     r_resp;

  axi_rw_top u_dut (
    .clock (clock), .rst_i (rst_i),
    .user_valid_i (user_valid_i), .user_op_i (user_op_i), .user_addr_i (user_addr_i),
    .user_size_i (user_size_i), .user_blks_i (user_blks_i), .user_wdata_i (user_wdata_i),
    .user_ready_o (user_ready_o), .user_rdata_o (user_rdata_o), .user_resp_o (user_resp_o),
    .aw_valid_o (aw_valid), .aw_ready_i (aw_ready), .aw_addr_o (aw_addr),
    .aw_len_o (aw_len), .aw_size_o (aw_size),
    .w_valid_o (w_valid), .w_ready_i (w_ready), .w_data_o (w_data),
    .w_strb_o (w_strb), .w_last_o (w_last),
    .b_valid_i (b_valid), .b_ready_o (b_ready), .b_resp_i (b_resp),
    .ar_valid_o (ar_valid), .ar_ready_i (ar_ready), .ar_addr_o (ar_addr),
    .ar_len_o (ar_len), .ar_size_o (ar_size),
    .r_valid_i (r_valid), .r_ready_o (r_ready), .r_data_i (r_data),
    .r_resp_i (r_resp), .r_last_i (r_last)
  );

  axi_slave_model #(.ERR_FIRST(ERR_FIRST)) u_slave (
    .clock (clock), .stall_i (stall),
    .aw_valid_i (aw_valid), .aw_ready_o (aw_ready), .aw_addr_i (aw_addr),
    .w_valid_i (w_valid), .w_ready_o (w_ready), .w_data_i (w_data),
    .w_strb_i (w_strb), .w_last_i (w_last),
    .b_valid_o (b_valid), .b_ready_i (b_ready), .b_resp_o (b_resp),
    .ar_valid_i (ar_valid), .ar_ready_o (ar_ready), .ar_addr_i (ar_addr),
    .ar_len_i (ar_len),
    .r_valid_o (r_valid), .r_ready_i (r_ready), .r_data_o (r_data),
    .r_resp_o (r_resp), .r_last_o (r_last)
  );

  initial begin
    clock = 1'b0;
    forever #50 clock = ~clock;
  end

  // ##################################################
  // helpers
  // ##################################################
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};   // taps 32 22 2 1
  endfunction

  function automatic logic [63:0] rand_bits(input int n);
    logic [63:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      r = {r[62:0], lfsr_state[0]};
    end
    return r;
  endfunction

  // 2^size bytes at the byte offset, a whole beat for size 3
  function automatic logic [7:0] strobe_for(input logic [1:0] size, input logic [2:0] ofs);
    logic [7:0] m;
    m = 8'((9'd1 << (4'd1 << size)) - 9'd1);
    if (size != 2'd3) m = m << ofs;
    return m;
  endfunction

  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
    if (got !== exp) begin
      $display("FAIL at %0t: %s is %h, expected %h", $time, name, got, exp);
      $display("Simulation FAILED");
      $fatal(1, "%s mismatch", name);
    end
  endtask

  // address, beats minus one and size of the request
  task automatic verify_addr_channel(input string ch, input logic [63:0] addr,
                                     input logic [7:0] len, input logic [2:0] size,
                                     input req_t e);
    check_value({ch, "_addr_o"}, addr, e.addr);
    check_value({ch, "_len_o"}, 64'(len), 64'(e.blks));
    check_value({ch, "_size_o"}, 64'(size), 64'(e.size));
  endtask

  // expected results follow a shadow of the slave memory
  task automatic build_table();
    req_t        e;
    logic [7:0]  idx;
    logic [7:0]  strb;
    logic [63:0] wbeat;
    for (int i = 0; i < 256; i++) shadow[i] = u_slave.mem[i];
    for (int pass = 0; pass < 2; pass++) begin
      for (int k = 0; k < NUM_BASE; k++) begin
        e = '0;
        e.op    = base_op[k];
        e.addr  = base_addr[k];
        e.size  = base_size[k];
        e.blks  = base_blks[k];
        e.stall = (pass == 1);
        for (int b = 0; b < `AXI_LINE_BEATS; b++) e.wline[64*b +: 64] = rand_bits(64);
        e.exp_resp = axi_rw_pkg::okay;
        strb = strobe_for(e.size, e.addr[2:0]);
        for (int b = 0; b <= int'(e.blks); b++) begin
          idx   = e.addr[10:3] + 8'(b);
          wbeat = e.wline[64*b +: 64];
          if (idx >= ERR_FIRST) e.exp_resp = axi_rw_pkg::slverr;
          if (e.op == axi_rw_pkg::op_read) begin
            e.exp_line[64*b +: 64] = shadow[idx];
          end else if (idx < ERR_FIRST) begin
            for (int j = 0; j < 8; j++) begin
              if (strb[j]) shadow[idx][8*j +: 8] = wbeat[8*j +: 8];
            end
          end
        end
        reqs.push_back(e);
      end
    end
  endtask

  task automatic run_request(input int n, input req_t e);
    int waited;
    @(negedge clock);
    stall_on     = e.stall;
    user_valid_i = 1'b1;
    user_op_i    = e.op;
    user_addr_i  = e.addr;
    user_size_i  = e.size;
    user_blks_i  = e.blks;
    user_wdata_i = e.wline;
    waited = 0;
    do begin
      @(negedge clock);
      waited++;
      if (waited > TIMEOUT_CYCLES) begin
        $display("request %0d got no user_ready_o within %0d cycles", n, TIMEOUT_CYCLES);
        $display("Simulation FAILED");
        $fatal(1, "timeout");
      end
      if (aw_valid) verify_addr_channel("aw", aw_addr, aw_len, aw_size, e);
      if (ar_valid) verify_addr_channel("ar", ar_addr, ar_len, ar_size, e);
    end while (!user_ready_o);
    check_value("user_resp_o", 64'(user_resp_o), 64'(e.exp_resp));
    if (e.op == axi_rw_pkg::op_read) begin
      for (int b = 0; b <= int'(e.blks); b++) begin
        check_value($sformatf("user_rdata_o[%0d]", b), user_rdata_o[64*b +: 64],
                    e.exp_line[64*b +: 64]);
      end
    end
    user_valid_i = 1'b0;
  endtask

  // stall pattern changes on the rising edge so the slave sees it settled
  initial begin
    stall = '0;
    forever begin
      @(posedge clock);
      if (stall_on) stall <= 5'(rand_bits(5));
      else stall <= '0;
    end
  end

  // ##################################################
  // main sequence
  // ##################################################
  initial begin
    rst_i        = 1'b1;
    stall_on     = 1'b0;
    user_valid_i = 1'b0;
    user_op_i    = axi_rw_pkg::op_read;
    user_addr_i  = '0;
    user_size_i  = '0;
    user_blks_i  = '0;
    user_wdata_i = '0;
    repeat (3) @(negedge clock);
    rst_i = 1'b0;
    @(negedge clock);
    check_value("aw_valid_o", 64'(aw_valid), 64'd0);
    check_value("w_valid_o", 64'(w_valid), 64'd0);
    check_value("ar_valid_o", 64'(ar_valid), 64'd0);
    check_value("user_ready_o", 64'(user_ready_o), 64'd0);
    build_table();
    foreach (reqs[i]) run_request(i, reqs[i]);
    $display("Simulation PASSED");
    $finish;
  end

endmodule

// ==== axi_rw_top.f ====
+incdir+include
rtl/axi_rw_pkg.sv
rtl/axi_beat_if.sv
rtl/axi_rw_fsm.sv
rtl/axi_beat_counter.sv
rtl/axi_wdata_shifter.sv
rtl/axi_rdata_collector.sv
rtl/axi_rw_top.sv
tests/axi_slave_model.sv
tests/tb_axi_rw.sv

// ==== Makefile ====
# Verilator flow for the AXI read/write bridge
# override any variable on the command line, e.g. make sim LOG=run.log

VERILATOR ?= verilator
TOP       ?= tb_axi_rw
FILELIST  ?= axi_rw_top.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert

SOURCES := $(shell grep -v '^+' $(FILELIST)) $(wildcard include/*.svh)
BINARY  := $(BUILD_DIR)/V$(TOP)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

$(BINARY): $(SOURCES) $(FILELIST)
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
		-Mdir $(BUILD_DIR) -o V$(TOP)

# the log decides the result, not the exit code of the run
sim: $(BINARY)
	./$(BINARY) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "^Simulation PASSED$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
